//--- src/bp_pkg.sv
// branch predictor update types
package bp_pkg;

    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W      = 3;
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;
    localparam int CTR_ENTRIES = 64;
    localparam int CTR_IDX_W   = 6;
    localparam int BTB_TAG_W   = 30 - BTB_IDX_W - 1;   // pc bits above the btb index

    typedef logic [29:0]          word_addr_t;
    typedef logic [1:0]           ctr_t;
    typedef logic [QPTR_W-1:0]    qptr_t;
    typedef logic [QPTR_W:0]      qcnt_t;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [BTB_TAG_W-1:0] btb_tag_t;
    typedef logic [CTR_IDX_W-1:0] ctr_idx_t;

    typedef enum logic [2:0] {
        NOT_JUMP      = 3'd0,
        DIRECT_JUMP   = 3'd1,
        CALL          = 3'd2,
        RET           = 3'd3,
        INDIRECT_JUMP = 3'd4,
        OTHER_JUMP    = 3'd5
    } br_kind_e;

    // choice is the counter as read at prediction time
    typedef struct packed {
        logic       taken;
        br_kind_e   kind;
        word_addr_t npc;
        ctr_t       choice;
    } pred_t;

    typedef struct packed {
        word_addr_t pc;
        pred_t      pred;
        logic       act_taken;
        br_kind_e   act_kind;
        word_addr_t act_npc;
    } resolved_t;

    typedef struct packed {
        logic [1:0]      lane_valid;
        resolved_t [1:0] lane;       // lane 0 older
    } exec_pair_t;

    typedef struct packed {
        resolved_t res;
        logic      mispredict;
    } queue_entry_t;

    typedef struct packed {
        word_addr_t pc;
        pred_t      pred;
        logic       taken;
        br_kind_e   kind;
        word_addr_t npc;
    } update_rec_t;

endpackage

//--- src/br_resolve.sv
// branch resolve stage
module br_resolve (
    input  logic                       clk,
    input  logic                       rstn,
    input  bp_pkg::exec_pair_t         exec_pair,
    input  logic                       exec_valid,
    output logic                       exec_ready,
    output bp_pkg::queue_entry_t [1:0] res_pair,
    output logic [1:0]                 res_lane_valid,
    output logic                       res_valid,
    input  logic                       res_ready,
    output logic                       redirect_valid,
    output bp_pkg::word_addr_t         redirect_pc
);
    import bp_pkg::*;

    logic       run;            // low for the first cycle out of reset
    logic       stage_valid;
    logic       take;
    logic [1:0] mispredict;
    logic [1:0] keep;
    resolved_t  mp_lane;

    function automatic logic lane_mispredict(resolved_t r);
        return (r.pred.taken != r.act_taken) ||
               (r.pred.taken && r.act_taken && (r.pred.npc != r.act_npc));
    endfunction

    assign exec_ready = run && (!stage_valid || res_ready);
    assign take       = exec_valid && exec_ready;
    assign res_valid  = stage_valid;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            mispredict[i] = exec_pair.lane_valid[i] && lane_mispredict(exec_pair.lane[i]);
        end
        keep[0] = exec_pair.lane_valid[0];
        keep[1] = exec_pair.lane_valid[1] && !mispredict[0];   // younger lane is on the wrong path
        mp_lane = mispredict[0] ? exec_pair.lane[0] : exec_pair.lane[1];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run            <= 1'b0;
            stage_valid    <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            run            <= 1'b1;
            redirect_valid <= take && (mispredict != 2'b00);
            if (take)
                stage_valid <= 1'b1;
            else if (res_ready)
                stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            for (int i = 0; i < 2; i++) begin
                res_pair[i].res        <= exec_pair.lane[i];
                res_pair[i].mispredict <= mispredict[i];
            end
            res_lane_valid <= keep;
            // fall through when the branch was actually not taken
            redirect_pc <= mp_lane.act_taken ? mp_lane.act_npc
                                             : mp_lane.pc + word_addr_t'(1);
        end
    end

endmodule

//--- src/update_queue.sv
// resolved branch update queue
module update_queue (
    input  logic                       clk,
    input  logic                       rstn,
    input  bp_pkg::queue_entry_t [1:0] res_pair,
    input  logic [1:0]                 res_lane_valid,
    input  logic                       res_valid,
    output logic                       res_ready,
    output logic                       upd_valid,
    output bp_pkg::update_rec_t        upd_rec
);
    import bp_pkg::*;

    queue_entry_t mem [QUEUE_DEPTH];

    qptr_t        head;
    qptr_t        tail;
    qptr_t        head_nxt;
    qptr_t        tail_nxt;
    qcnt_t        count;

    queue_entry_t e;
    queue_entry_t f;
    logic         has_e;
    logic         has_f;
    logic         adjacent;
    logic         pop_one;
    logic         pop_two;
    logic         push;
    logic [1:0]   n_push;
    logic [1:0]   n_pop;
    update_rec_t  rec_d;

    function automatic br_kind_e merge_kind(br_kind_e a, br_kind_e b);
        br_kind_e k;
        if (a == DIRECT_JUMP || b == DIRECT_JUMP)
            k = DIRECT_JUMP;
        else if (a == CALL || b == CALL)
            k = CALL;
        else if (a == RET || b == RET)
            k = RET;
        else if (a == INDIRECT_JUMP || b == INDIRECT_JUMP)
            k = INDIRECT_JUMP;
        else if (a == OTHER_JUMP || b == OTHER_JUMP)
            k = OTHER_JUMP;
        else
            k = NOT_JUMP;
        return k;
    endfunction

    assign head_nxt  = head + qptr_t'(1);
    assign tail_nxt  = tail + qptr_t'(1);
    assign res_ready = count <= qcnt_t'(QUEUE_DEPTH - 2);   // room for a full pair
    assign push      = res_valid && res_ready;
    assign n_push    = push ? {1'b0, res_lane_valid[0]} + {1'b0, res_lane_valid[1]} : 2'd0;

    assign e        = mem[head];
    assign f        = mem[head_nxt];
    assign has_e    = count != '0;
    assign has_f    = count > qcnt_t'(1);
    assign adjacent = has_f && (f.res.pc == e.res.pc + word_addr_t'(1));

    // even slot with its partner right behind it
    assign pop_two = adjacent && !e.res.pc[0] && !e.mispredict;
    // any F here is either not the partner or E cannot pair with it
    assign pop_one = has_e && !pop_two && (e.res.pc[0] || e.mispredict || has_f);
    assign n_pop   = pop_two ? 2'd2 : (pop_one ? 2'd1 : 2'd0);

    always_comb begin
        rec_d.pc   = e.res.pc;
        rec_d.pred = e.res.pred;
        if (pop_two) begin
            rec_d.taken = e.res.act_taken || f.res.act_taken;
            rec_d.kind  = merge_kind(e.res.act_kind, f.res.act_kind);
            rec_d.npc   = e.res.act_taken ? e.res.act_npc : f.res.act_npc;
        end else begin
            rec_d.taken = e.res.act_taken;
            rec_d.kind  = e.res.act_kind;
            rec_d.npc   = e.res.act_npc;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            upd_valid <= 1'b0;
        end else begin
            tail      <= tail + qptr_t'(n_push);
            head      <= head + qptr_t'(n_pop);
            count     <= count + qcnt_t'(n_push) - qcnt_t'(n_pop);
            upd_valid <= pop_one || pop_two;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            if (res_lane_valid[0]) begin
                mem[tail] <= res_pair[0];
                if (res_lane_valid[1])
                    mem[tail_nxt] <= res_pair[1];
            end else if (res_lane_valid[1]) begin
                mem[tail] <= res_pair[1];   // lone younger lane
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_one || pop_two)
            upd_rec <= rec_d;
    end

endmodule

//--- src/pred_tables.sv
// btb and direction counters
module pred_tables (
    input  logic                clk,
    input  logic                rstn,
    input  logic                upd_valid,
    input  bp_pkg::update_rec_t upd_rec,
    input  bp_pkg::word_addr_t  lookup_pc,
    output bp_pkg::pred_t       lookup_pred
);
    import bp_pkg::*;

    logic       btb_valid  [BTB_ENTRIES];
    btb_tag_t   btb_tag    [BTB_ENTRIES];
    br_kind_e   btb_kind   [BTB_ENTRIES];
    word_addr_t btb_target [BTB_ENTRIES];
    ctr_t       ctr        [CTR_ENTRIES];

    ctr_idx_t   upd_ctr_idx;
    btb_idx_t   upd_btb_idx;
    ctr_t       ctr_next;

    ctr_idx_t   lk_ctr_idx;
    btb_idx_t   lk_btb_idx;
    ctr_t       lk_ctr;
    logic       lk_hit;
    logic       lk_taken;

    function automatic ctr_idx_t ctr_index(word_addr_t pc);
        return pc[CTR_IDX_W:1];
    endfunction

    function automatic btb_idx_t btb_index(word_addr_t pc);
        return pc[BTB_IDX_W:1];
    endfunction

    function automatic btb_tag_t btb_tag_of(word_addr_t pc);
        return pc[29:BTB_IDX_W+1];
    endfunction

    assign upd_ctr_idx = ctr_index(upd_rec.pc);
    assign upd_btb_idx = btb_index(upd_rec.pc);

    // saturating step from the value seen at prediction
    always_comb begin
        ctr_next = upd_rec.pred.choice;
        if (upd_rec.taken && ctr_next != 2'd3)
            ctr_next = ctr_next + 2'd1;
        else if (!upd_rec.taken && ctr_next != 2'd0)
            ctr_next = ctr_next - 2'd1;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < CTR_ENTRIES; i++) begin
                ctr[i] <= '0;
            end
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (upd_valid) begin
            ctr[upd_ctr_idx] <= ctr_next;
            if (upd_rec.taken)
                btb_valid[upd_btb_idx] <= 1'b1;
        end
    end

    // only taken packets allocate
    always_ff @(posedge clk) begin
        if (upd_valid && upd_rec.taken) begin
            btb_tag[upd_btb_idx]    <= btb_tag_of(upd_rec.pc);
            btb_kind[upd_btb_idx]   <= upd_rec.kind;
            btb_target[upd_btb_idx] <= upd_rec.npc;
        end
    end

    assign lk_ctr_idx = ctr_index(lookup_pc);
    assign lk_btb_idx = btb_index(lookup_pc);
    assign lk_ctr     = ctr[lk_ctr_idx];
    assign lk_hit     = btb_valid[lk_btb_idx] && (btb_tag[lk_btb_idx] == btb_tag_of(lookup_pc));
    assign lk_taken   = lk_hit && lk_ctr[1];

    always_comb begin
        lookup_pred.choice = lk_ctr;
        lookup_pred.taken  = lk_taken;
        lookup_pred.kind   = lk_hit ? btb_kind[lk_btb_idx] : NOT_JUMP;
        if (lk_taken)
            lookup_pred.npc = btb_target[lk_btb_idx];
        else
            lookup_pred.npc = {lookup_pc[29:1], 1'b0} + word_addr_t'(2);   // next packet
    end

endmodule

//--- src/bp_update_top.sv
// predictor update path top
module bp_update_top (
    input  logic                clk,
    input  logic                rstn,
    input  bp_pkg::exec_pair_t  exec_pair,
    input  logic                exec_valid,
    output logic                exec_ready,
    output logic                redirect_valid,
    output bp_pkg::word_addr_t  redirect_pc,
    output logic                upd_valid,
    output bp_pkg::update_rec_t upd_rec,
    input  bp_pkg::word_addr_t  lookup_pc,
    output bp_pkg::pred_t       lookup_pred
);
    import bp_pkg::*;

    queue_entry_t [1:0] res_pair;
    logic [1:0]         res_lane_valid;
    logic               res_valid;
    logic               res_ready;

    br_resolve br_resolve_i (
        .clk            (clk),
        .rstn           (rstn),
        .exec_pair      (exec_pair),
        .exec_valid     (exec_valid),
        .exec_ready     (exec_ready),
        .res_pair       (res_pair),
        .res_lane_valid (res_lane_valid),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    update_queue update_queue_i (
        .clk            (clk),
        .rstn           (rstn),
        .res_pair       (res_pair),
        .res_lane_valid (res_lane_valid),
        .res_valid      (res_valid),
        .res_ready      (res_ready),
        .upd_valid      (upd_valid),
        .upd_rec        (upd_rec)
    );

    // records also leave the top for the return-address stack
    pred_tables pred_tables_i (
        .clk         (clk),
        .rstn        (rstn),
        .upd_valid   (upd_valid),
        .upd_rec     (upd_rec),
        .lookup_pc   (lookup_pc),
        .lookup_pred (lookup_pred)
    );

endmodule

//--- tests/tb_bp_update.sv
// predictor update path testbench
module tb_bp_update;
    timeunit 1ns;
    timeprecision 100ps;
    import bp_pkg::*;

    localparam int MAX_CYCLES = 2000;   // all tests together need a few hundred

    logic        clk = 1'b0;
    logic        rstn;
    exec_pair_t  exec_pair;
    logic        exec_valid;
    logic        exec_ready;
    logic        redirect_valid;
    word_addr_t  redirect_pc;
    logic        upd_valid;
    update_rec_t upd_rec;
    word_addr_t  lookup_pc;
    pred_t       lookup_pred;

    int errors = 0;
    int cycle = 0;
    int hs_cycle = 0;
    int stalls = 0;
    int rec_done = 0;
    int redir_done = 0;

    queue_entry_t mq[$];        // surviving entries not yet popped
    exec_pair_t   tx[$];
    update_rec_t  exp_recs[$];
    update_rec_t  got[$];
    int           got_cyc[$];
    word_addr_t   exp_redir[$];
    word_addr_t   got_redir[$];

    // reference tables
    logic        m_valid  [BTB_ENTRIES];
    logic [24:0] m_tag    [BTB_ENTRIES];
    br_kind_e    m_kind   [BTB_ENTRIES];
    word_addr_t  m_target [BTB_ENTRIES];
    ctr_t        m_ctr    [CTR_ENTRIES];

    bp_update_top bp_update_top_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycle);
            $display("%0d errors", errors);
            $display("test failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rstn && upd_valid) begin
            got.push_back(upd_rec);
            got_cyc.push_back(cycle);
        end
        if (rstn && redirect_valid)
            got_redir.push_back(redirect_pc);
    end

    task automatic check(string name, logic [127:0] got_v, logic [127:0] exp_v);
        if (got_v !== exp_v) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got_v, exp_v);
        end
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic word_addr_t rand_pc();
        return word_addr_t'($urandom()) & ~word_addr_t'(7);
    endfunction

    // mp 0 gives a correct lane, 1 a wrong direction and 2 a wrong target
    function automatic resolved_t make_lane(word_addr_t pc, logic taken, br_kind_e kind,
                                            word_addr_t npc, int mp, ctr_t choice);
        resolved_t r;
        r.pc          = pc;
        r.act_taken   = taken;
        r.act_kind    = kind;
        r.act_npc     = npc;
        r.pred.taken  = (mp == 1) ? !taken : taken;
        r.pred.kind   = kind;
        r.pred.npc    = (mp == 2) ? npc + word_addr_t'(3) : npc;
        r.pred.choice = choice;
        return r;
    endfunction

    function automatic exec_pair_t make_pair(logic [1:0] v, resolved_t l0, resolved_t l1);
        exec_pair_t p;
        p.lane_valid = v;
        p.lane[0]    = l0;
        p.lane[1]    = l1;
        return p;
    endfunction

    function automatic int kind_rank(br_kind_e k);
        return (k == NOT_JUMP) ? 0 : 6 - int'(k);   // direct jump ranks highest
    endfunction

    function automatic pred_t model_lookup(word_addr_t pc);
        pred_t p;
        logic  hit;
        hit      = m_valid[pc[4:1]] && (m_tag[pc[4:1]] == pc[29:5]);
        p.choice = m_ctr[pc[6:1]];
        p.taken  = hit && p.choice[1];
        p.kind   = hit ? m_kind[pc[4:1]] : NOT_JUMP;
        p.npc    = p.taken ? m_target[pc[4:1]] : {pc[29:1], 1'b0} + word_addr_t'(2);
        return p;
    endfunction

    task automatic apply_tables(update_rec_t r);
        ctr_t c;
        c = r.pred.choice;
        if (r.taken)
            c = (c == 2'd3) ? c : c + 2'd1;
        else
            c = (c == 2'd0) ? c : c - 2'd1;
        m_ctr[r.pc[6:1]] = c;
        if (r.taken) begin
            m_valid[r.pc[4:1]]  = 1'b1;
            m_tag[r.pc[4:1]]    = r.pc[29:5];
            m_kind[r.pc[4:1]]   = r.kind;
            m_target[r.pc[4:1]] = r.npc;
        end
    endtask

    task automatic model_drain();
        queue_entry_t e;
        queue_entry_t f;
        update_rec_t  rec;
        logic         two;
        while (mq.size() > 0) begin
            e   = mq[0];
            two = 1'b0;
            if (!e.res.pc[0] && !e.mispredict) begin
                if (mq.size() < 2)
                    break;              // lone even slot waits for its partner
                f   = mq[1];
                two = (f.res.pc == e.res.pc + word_addr_t'(1));
            end
            rec.pc    = e.res.pc;
            rec.pred  = e.res.pred;
            rec.taken = e.res.act_taken;
            rec.kind  = e.res.act_kind;
            rec.npc   = e.res.act_npc;
            if (two) begin
                rec.taken = e.res.act_taken || f.res.act_taken;
                if (kind_rank(f.res.act_kind) > kind_rank(e.res.act_kind))
                    rec.kind = f.res.act_kind;
                if (!e.res.act_taken)
                    rec.npc = f.res.act_npc;
                void'(mq.pop_front());
            end
            void'(mq.pop_front());
            exp_recs.push_back(rec);
            apply_tables(rec);
        end
    endtask

    task automatic issue(exec_pair_t p);
        logic [1:0] mp;
        resolved_t  r;
        for (int i = 0; i < 2; i++) begin
            r     = p.lane[i];
            mp[i] = p.lane_valid[i] && ((r.pred.taken != r.act_taken) ||
                    (r.pred.taken && r.act_taken && (r.pred.npc != r.act_npc)));
        end
        if (p.lane_valid[0])
            mq.push_back({p.lane[0], mp[0]});
        if (p.lane_valid[1] && !mp[0])
            mq.push_back({p.lane[1], mp[1]});
        if (mp != 2'b00) begin
            r = mp[0] ? p.lane[0] : p.lane[1];
            exp_redir.push_back(r.act_taken ? r.act_npc : r.pc + word_addr_t'(1));
        end
        model_drain();
        tx.push_back(p);
    endtask

    task automatic send_all();
        logic ready;
        while (tx.size() > 0) begin
            exec_pair  = tx[0];
            exec_valid = 1'b1;
            @(negedge clk);
            ready = exec_ready;
            if (!ready)
                stalls++;
            @(posedge clk);
            #1;
            if (ready) begin
                hs_cycle = cycle;
                void'(tx.pop_front());
            end
        end
        exec_valid = 1'b0;
    endtask

    task automatic check_records(int lat);
        while (got.size() < exp_recs.size() || got_redir.size() < exp_redir.size())
            wait_cycles(1);
        wait_cycles(3);         // room for stray records
        if (lat >= 0 && rec_done < exp_recs.size())
            check("upd_valid latency", 128'(got_cyc[rec_done] - hs_cycle), 128'(lat));
        if (got.size() != exp_recs.size() || got_redir.size() != exp_redir.size()) begin
            errors++;
            $display("got %0d records and %0d redirects, expected %0d and %0d",
                     got.size(), got_redir.size(), exp_recs.size(), exp_redir.size());
        end
        for (int i = rec_done; i < exp_recs.size(); i++)
            check("upd_rec", 128'(got[i]), 128'(exp_recs[i]));
        for (int i = redir_done; i < exp_redir.size(); i++)
            check("redirect_pc", 128'(got_redir[i]), 128'(exp_redir[i]));
        rec_done   = exp_recs.size();
        redir_done = exp_redir.size();
    endtask

    task automatic check_lookup(word_addr_t pc);
        lookup_pc = pc;
        @(negedge clk);
        check("lookup_pred", 128'(lookup_pred), 128'(model_lookup(pc)));
        wait_cycles(1);
    endtask

    task automatic reset_state();
        @(negedge clk);
        check("exec_ready", 128'(exec_ready), 128'(1'b0));
        check("redirect_valid", 128'(redirect_valid), 128'(1'b0));
        check("upd_valid", 128'(upd_valid), 128'(1'b0));
        wait_cycles(1);
        repeat (4) check_lookup(rand_pc() | word_addr_t'($urandom_range(7)));
    endtask

    task automatic single_pops();
        word_addr_t p;
        p = rand_pc();
        issue(make_pair(2'b01,
                        make_lane(p | word_addr_t'(1), 1'b1, DIRECT_JUMP, rand_pc(), 0, 2'd1),
                        make_lane(p, 1'b0, NOT_JUMP, p, 0, 2'd0)));
        send_all();
        check_records(2);
        p = rand_pc();      // partner slot pc is not consecutive
        issue(make_pair(2'b11,
                        make_lane(p, 1'b0, NOT_JUMP, p + word_addr_t'(1), 0, 2'd2),
                        make_lane(p + word_addr_t'(5), 1'b1, OTHER_JUMP, rand_pc(), 0, 2'd3)));
        send_all();
        check_records(2);
    endtask

    task automatic pair_merge();
        logic       t0 [4] = '{1'b0, 1'b0, 1'b1, 1'b1};
        logic       t1 [4] = '{1'b0, 1'b1, 1'b0, 1'b1};
        br_kind_e   k0 [4] = '{NOT_JUMP, NOT_JUMP, CALL, OTHER_JUMP};
        br_kind_e   k1 [4] = '{NOT_JUMP, INDIRECT_JUMP, RET, DIRECT_JUMP};
        word_addr_t p;
        for (int i = 0; i < 4; i++) begin
            p = rand_pc();
            issue(make_pair(2'b11,
                            make_lane(p, t0[i], k0[i], t0[i] ? rand_pc() : p + word_addr_t'(1),
                                      0, ctr_t'($urandom())),
                            make_lane(p + word_addr_t'(1), t1[i], k1[i],
                                      t1[i] ? rand_pc() : p + word_addr_t'(2),
                                      0, ctr_t'($urandom()))));
            send_all();
            check_records(2);
        end
    endtask

    task automatic mispredicts();
        word_addr_t p;
        for (int i = 0; i < 4; i++) begin
            p = rand_pc();
            case (i)
                0: issue(make_pair(2'b11, make_lane(p, 1'b1, DIRECT_JUMP, rand_pc(), 1, 2'd0),
                                   make_lane(p + 1, 1'b0, NOT_JUMP, p + 2, 0, 2'd0)));
                1: issue(make_pair(2'b11, make_lane(p, 1'b1, INDIRECT_JUMP, rand_pc(), 2, 2'd1),
                                   make_lane(p + 1, 1'b1, CALL, rand_pc(), 0, 2'd1)));
                2: issue(make_pair(2'b11, make_lane(p, 1'b0, NOT_JUMP, p + 1, 1, 2'd2),
                                   make_lane(p + 1, 1'b0, NOT_JUMP, p + 2, 0, 2'd2)));
                default: issue(make_pair(2'b11, make_lane(p, 1'b0, NOT_JUMP, p + 1, 0, 2'd3),
                                         make_lane(p + 1, 1'b1, RET, rand_pc(), 1, 2'd3)));
            endcase
            send_all();
            check_records(-1);
        end
    endtask

    task automatic table_training();
        word_addr_t p;
        word_addr_t t;
        ctr_t       ch;
        p = rand_pc();
        t = rand_pc();
        for (int i = 0; i < 8; i++) begin
            ch = m_ctr[p[6:1]];     // what fetch would have seen
            issue(make_pair(2'b11, make_lane(p, 1'b0, NOT_JUMP, p + 1, 0, ch),
                            make_lane(p + 1, i < 4, CALL, (i < 4) ? t : p + 2, 0, ch)));
            send_all();
            check_records(-1);
            check_lookup(p);
        end
    endtask

    task automatic backpressure();
        word_addr_t base;
        word_addr_t a;
        base   = rand_pc();
        stalls = 0;
        for (int i = 0; i < 10; i++) begin
            a = base + word_addr_t'(16 * i);
            issue(make_pair(2'b11, make_lane(a, 1'b0, NOT_JUMP, a + 1, 0, 2'd0),
                            make_lane(a + 2, 1'b1, DIRECT_JUMP, rand_pc(), 0, 2'd1)));
        end
        send_all();
        if (stalls == 0) begin
            errors++;
            $display("exec_ready never dropped while the queue was filling");
        end
        for (int i = 0; i < 10; i++) begin
            a = base + word_addr_t'(16 * i);
            issue(make_pair(2'b11, make_lane(a + 1, 1'b1, CALL, rand_pc(), 0, 2'd2),
                            make_lane(a + 3, 1'b0, NOT_JUMP, a + 4, 0, 2'd3)));
        end
        send_all();
        check_records(-1);
    endtask

    initial begin
        void'($urandom(98082));
        rstn       = 1'b0;
        exec_valid = 1'b0;
        exec_pair  = '0;
        lookup_pc  = '0;
        for (int i = 0; i < BTB_ENTRIES; i++)
            m_valid[i] = 1'b0;
        for (int i = 0; i < CTR_ENTRIES; i++)
            m_ctr[i] = 2'd0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        reset_state();
        single_pops();
        pair_merge();
        mispredicts();
        table_training();
        backpressure();

        $display("%0d errors in %0d records and %0d redirects", errors, rec_done, redir_done);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- sim.f
src/bp_pkg.sv
src/br_resolve.sv
src/update_queue.sv
src/pred_tables.sv
src/bp_update_top.sv
tests/tb_bp_update.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_bp_update -f sim.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "simulation did not report a pass, see sim.log" >&2
exit 1
